// File: source/mem_axi_settings.svh
// ##############################
// AXI memory subsystem sizes
// ##############################

`ifndef MEM_AXI_SETTINGS_SVH
`define MEM_AXI_SETTINGS_SVH

`define MEM_AXI_ADDR_WIDTH        16   // byte address
`define MEM_AXI_DATA_WIDTH        32
`define MEM_AXI_ID_WIDTH          4
`define MEM_AXI_WRITE_FIFO_DEPTH  2    // write payloads waiting for W
`define MEM_AXI_AR_FIFO_DEPTH     2    // read bursts queued in the memory
`define MEM_AXI_MEM_WORDS         256

`endif

// File: source/mem_axi_pkg.sv
// ##############################
// AXI memory subsystem types
// ##############################

`include "mem_axi_settings.svh"

package mem_axi_pkg;

  localparam int unsigned STRB_WIDTH = `MEM_AXI_DATA_WIDTH / 8;

  // RISC-V AMO encoding as it comes from the load/store unit
  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4,
    AMO_XOR  = 4'h5,
    AMO_MAX  = 4'h6,
    AMO_MAXU = 4'h7,
    AMO_MIN  = 4'h8,
    AMO_MINU = 4'h9,
    AMO_LR   = 4'hA,
    AMO_SC   = 4'hB
  } amo_op_t;

  // AXI5 atop field, zero means a normal write
  typedef logic [5:0] atop_t;

  localparam logic [1:0] ATOP_ATOMICLOAD = 2'b10;
  localparam logic       ATOP_LITTLE_END = 1'b0;
  localparam atop_t      ATOP_ATOMICSWAP = 6'b110000;

  // low three bits of an atomic load select the operation
  localparam logic [2:0] ATOP_ADD  = 3'b000;
  localparam logic [2:0] ATOP_CLR  = 3'b001;
  localparam logic [2:0] ATOP_EOR  = 3'b010;
  localparam logic [2:0] ATOP_SET  = 3'b011;
  localparam logic [2:0] ATOP_SMAX = 3'b100;
  localparam logic [2:0] ATOP_SMIN = 3'b101;
  localparam logic [2:0] ATOP_UMAX = 3'b110;
  localparam logic [2:0] ATOP_UMIN = 3'b111;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  typedef struct packed {
    logic [`MEM_AXI_ID_WIDTH-1:0]   id;
    logic [`MEM_AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                     len;
    atop_t                          atop;
  } aw_chan_t;

  typedef struct packed {
    logic [`MEM_AXI_DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0]          strb;
    logic                           last;
  } w_chan_t;

  typedef struct packed {
    logic [`MEM_AXI_ID_WIDTH-1:0] id;
    resp_t                        resp;
  } b_chan_t;

  typedef struct packed {
    logic [`MEM_AXI_ID_WIDTH-1:0]   id;
    logic [`MEM_AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                     len;
  } ar_chan_t;

  typedef struct packed {
    logic [`MEM_AXI_ID_WIDTH-1:0]   id;
    logic [`MEM_AXI_DATA_WIDTH-1:0] data;
    resp_t                          resp;
    logic                           last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  typedef struct packed {
    logic [`MEM_AXI_ADDR_WIDTH-1:0] addr;
    logic                           write;
    amo_op_t                        amo;
    logic [`MEM_AXI_DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0]          strb;
    logic [7:0]                     rlen;  // beats minus one
    logic [`MEM_AXI_ID_WIDTH-1:0]   id;
  } core_req_t;

  typedef struct packed {
    logic [`MEM_AXI_DATA_WIDTH-1:0] data;
    logic [`MEM_AXI_ID_WIDTH-1:0]   id;
    logic                           error;
    logic                           last;
  } core_rsp_t;

endpackage

// File: source/stream_fifo.sv
`timescale 1ns/10ps
// ##############################
// Payload FIFO
// ##############################

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned ptr_w = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned cnt_w = $clog2(Depth + 1);

  payload_t         store_q [Depth];
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w-1:0] wr_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // pointers wrap at Depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == cnt_w'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;  // overflow is dropped
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = store_q[rd_ptr_q];  // head entry is always visible

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither leaves the level alone
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) store_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: source/axi_adapter.sv
`timescale 1ns/10ps
// ##############################
// Core to AXI adapter
// ##############################

`include "mem_axi_settings.svh"

module axi_adapter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_axi_pkg::core_req_t core_req_i,
  input  logic                   core_qvalid_i,
  output logic                   core_qready_o,
  output mem_axi_pkg::core_rsp_t core_rsp_o,
  output logic                   core_pvalid_o,
  input  logic                   core_pready_i,
  output mem_axi_pkg::axi_req_t  axi_req_o,
  input  mem_axi_pkg::axi_resp_t axi_resp_i
);

  import mem_axi_pkg::*;

  atop_t   atop;
  w_chan_t w_in;
  w_chan_t w_out;
  logic    w_full;
  logic    w_empty;
  logic    wr_req;
  logic    aw_hs;
  logic    ar_hs;

  // AMO mapping, every atomic keeps its load result so the core gets the old value
  always_comb begin
    atop      = '0;
    w_in.data = core_req_i.data;
    w_in.strb = core_req_i.strb;
    w_in.last = 1'b1;  // writes are always single beat
    unique case (core_req_i.amo)
      AMO_SWAP: atop = ATOP_ATOMICSWAP;
      AMO_ADD:  atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_ADD};
      AMO_AND: begin
        // the slave only knows clear, so and-ing with x means clearing ~x
        atop      = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_CLR};
        w_in.data = ~core_req_i.data;
      end
      AMO_OR:   atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_SET};
      AMO_XOR:  atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_EOR};
      AMO_MAX:  atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_SMAX};
      AMO_MAXU: atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_UMAX};
      AMO_MIN:  atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_SMIN};
      AMO_MINU: atop = {ATOP_ATOMICLOAD, ATOP_LITTLE_END, ATOP_UMIN};
      default:  atop = '0;  // none, lr and sc are plain accesses
    endcase
  end

  // atomics travel on the write channels even if the write flag is clear
  assign wr_req = core_req_i.write | (atop != '0);

  assign axi_req_o.aw.id   = core_req_i.id;
  assign axi_req_o.aw.addr = core_req_i.addr;
  assign axi_req_o.aw.len  = '0;
  assign axi_req_o.aw.atop = atop;
  // only offer AW when the payload has somewhere to go
  assign axi_req_o.aw_valid = core_qvalid_i & wr_req & ~w_full;

  assign aw_hs = axi_req_o.aw_valid & axi_resp_i.aw_ready;

  stream_fifo #(
    .payload_t ( w_chan_t                  ),
    .Depth     ( `MEM_AXI_WRITE_FIFO_DEPTH )
  ) i_write_fifo (
    .clk_i   ( clk_i                                   ),
    .rst_n_i ( rst_n_i                                 ),
    .push_i  ( aw_hs                                   ),
    .data_i  ( w_in                                    ),
    .pop_i   ( axi_req_o.w_valid & axi_resp_i.w_ready  ),
    .data_o  ( w_out                                   ),
    .full_o  ( w_full                                  ),
    .empty_o ( w_empty                                 )
  );

  assign axi_req_o.w       = w_out;
  assign axi_req_o.w_valid = ~w_empty;  // rises the cycle after the push
  assign axi_req_o.b_ready = 1'b1;  // write responses carry nothing for the core

  assign axi_req_o.ar.id    = core_req_i.id;
  assign axi_req_o.ar.addr  = core_req_i.addr;
  assign axi_req_o.ar.len   = core_req_i.rlen;
  assign axi_req_o.ar_valid = core_qvalid_i & ~wr_req;

  assign ar_hs = axi_req_o.ar_valid & axi_resp_i.ar_ready;

  // a request is done as soon as its address channel has been taken
  assign core_qready_o = aw_hs | ar_hs;

  // R goes straight through, only the response code is folded
  assign core_rsp_o.data  = axi_resp_i.r.data;
  assign core_rsp_o.id    = axi_resp_i.r.id;
  assign core_rsp_o.error = axi_resp_i.r.resp inside {RESP_SLVERR, RESP_DECERR};
  assign core_rsp_o.last  = axi_resp_i.r.last;
  assign core_pvalid_o    = axi_resp_i.r_valid;
  assign axi_req_o.r_ready = core_pready_i;

endmodule

// File: source/axi_atomic_mem.sv
`timescale 1ns/10ps
// ##############################
// AXI memory with atomics
// ##############################

`include "mem_axi_settings.svh"

module axi_atomic_mem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_axi_pkg::axi_req_t  axi_req_i,
  output mem_axi_pkg::axi_resp_t axi_resp_o
);

  import mem_axi_pkg::*;

  localparam int unsigned off_w  = $clog2(STRB_WIDTH);
  localparam int unsigned word_w = `MEM_AXI_ADDR_WIDTH - off_w;
  localparam int unsigned idx_w  = $clog2(`MEM_AXI_MEM_WORDS);

  typedef logic [`MEM_AXI_DATA_WIDTH-1:0] word_t;

  word_t mem_q [`MEM_AXI_MEM_WORDS];

  logic              aw_pend_q;
  aw_chan_t          aw_q;
  logic              b_valid_q;
  b_chan_t           b_q;
  logic              amo_valid_q;
  r_chan_t           amo_r_q;
  logic              aw_hs;
  logic              w_hs;
  logic [word_w-1:0] wr_word;
  logic              wr_in_range;
  logic              wr_atomic;
  word_t             wr_old;
  word_t             op_res;
  word_t             wr_new;

  ar_chan_t          ar_head;
  logic              ar_full;
  logic              ar_empty;
  logic              ar_pop;
  logic [7:0]        beat_q;
  logic              burst_hold_q;
  r_chan_t           hold_r_q;
  logic              sel_amo;
  logic              burst_valid;
  logic              burst_hs;
  logic              burst_last;
  logic [word_w:0]   rd_word;
  logic              rd_in_range;
  r_chan_t           live_r;
  r_chan_t           burst_r;

  // one write at a time, and none while an atomic result still waits for R
  assign axi_resp_o.aw_ready = ~aw_pend_q & ~amo_valid_q;
  assign axi_resp_o.w_ready  = aw_pend_q & (~b_valid_q | axi_req_i.b_ready);
  assign aw_hs = axi_req_i.aw_valid & axi_resp_o.aw_ready;
  assign w_hs  = axi_req_i.w_valid & axi_resp_o.w_ready;

  assign wr_word     = aw_q.addr[`MEM_AXI_ADDR_WIDTH-1:off_w];
  assign wr_in_range = (wr_word < word_w'(`MEM_AXI_MEM_WORDS));
  assign wr_old      = wr_in_range ? mem_q[wr_word[idx_w-1:0]] : '0;

  always_comb begin
    wr_atomic = 1'b0;
    op_res    = axi_req_i.w.data;
    if (aw_q.atop == ATOP_ATOMICSWAP) begin
      wr_atomic = 1'b1;
    end else if (aw_q.atop[5:4] == ATOP_ATOMICLOAD) begin
      wr_atomic = 1'b1;
      unique case (aw_q.atop[2:0])
        ATOP_ADD:  op_res = wr_old + axi_req_i.w.data;
        ATOP_CLR:  op_res = wr_old & ~axi_req_i.w.data;
        ATOP_EOR:  op_res = wr_old ^ axi_req_i.w.data;
        ATOP_SET:  op_res = wr_old | axi_req_i.w.data;
        ATOP_SMAX: op_res = ($signed(wr_old) > $signed(axi_req_i.w.data)) ? wr_old
                                                                         : axi_req_i.w.data;
        ATOP_SMIN: op_res = ($signed(wr_old) < $signed(axi_req_i.w.data)) ? wr_old
                                                                         : axi_req_i.w.data;
        ATOP_UMAX: op_res = (wr_old > axi_req_i.w.data) ? wr_old : axi_req_i.w.data;
        ATOP_UMIN: op_res = (wr_old < axi_req_i.w.data) ? wr_old : axi_req_i.w.data;
        default:   op_res = axi_req_i.w.data;
      endcase
    end
  end

  // strobes apply to atomics too, unselected bytes keep the old value
  always_comb begin
    for (int b = 0; b < STRB_WIDTH; b++) begin
      wr_new[8*b +: 8] = axi_req_i.w.strb[b] ? op_res[8*b +: 8] : wr_old[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_pend_q   <= 1'b0;
      b_valid_q   <= 1'b0;
      amo_valid_q <= 1'b0;
    end else begin
      if (aw_hs) aw_pend_q <= 1'b1;
      else if (w_hs) aw_pend_q <= 1'b0;
      if (w_hs) b_valid_q <= 1'b1;
      else if (axi_req_i.b_ready) b_valid_q <= 1'b0;
      if (w_hs && wr_atomic) amo_valid_q <= 1'b1;
      else if (sel_amo && axi_req_i.r_ready) amo_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) aw_q <= axi_req_i.aw;
    if (w_hs) begin
      if (wr_in_range) mem_q[wr_word[idx_w-1:0]] <= wr_new;  // out of range is dropped
      b_q.id       <= aw_q.id;
      b_q.resp     <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      amo_r_q.id   <= aw_q.id;
      amo_r_q.data <= wr_old;  // the load part of the atomic
      amo_r_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      amo_r_q.last <= 1'b1;
    end
  end

  assign axi_resp_o.b       = b_q;
  assign axi_resp_o.b_valid = b_valid_q;

  stream_fifo #(
    .payload_t ( ar_chan_t              ),
    .Depth     ( `MEM_AXI_AR_FIFO_DEPTH )
  ) i_ar_fifo (
    .clk_i   ( clk_i                                    ),
    .rst_n_i ( rst_n_i                                  ),
    .push_i  ( axi_req_i.ar_valid & axi_resp_o.ar_ready ),
    .data_i  ( axi_req_i.ar                             ),
    .pop_i   ( ar_pop                                   ),
    .data_o  ( ar_head                                  ),
    .full_o  ( ar_full                                  ),
    .empty_o ( ar_empty                                 )
  );

  assign axi_resp_o.ar_ready = ~ar_full;

  assign rd_word     = {1'b0, ar_head.addr[`MEM_AXI_ADDR_WIDTH-1:off_w]} + (word_w + 1)'(beat_q);
  assign rd_in_range = (rd_word < (word_w + 1)'(`MEM_AXI_MEM_WORDS));
  assign burst_last  = (beat_q == ar_head.len);

  always_comb begin
    live_r.id   = ar_head.id;
    live_r.data = rd_in_range ? mem_q[rd_word[idx_w-1:0]] : '0;
    live_r.resp = rd_in_range ? RESP_OKAY : RESP_SLVERR;
    live_r.last = burst_last;
  end

  // a stalled beat keeps the data it was first shown with
  assign burst_r = burst_hold_q ? hold_r_q : live_r;

  // the atomic beat may only step in when no burst beat is on the bus
  assign sel_amo     = amo_valid_q & ~burst_hold_q;
  assign burst_valid = ~ar_empty & ~sel_amo;
  assign burst_hs    = burst_valid & axi_req_i.r_ready;
  assign ar_pop      = burst_hs & burst_last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_q       <= '0;
      burst_hold_q <= 1'b0;
    end else begin
      burst_hold_q <= burst_valid & ~axi_req_i.r_ready;
      if (burst_hs) beat_q <= burst_last ? '0 : beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!burst_hold_q) hold_r_q <= live_r;
  end

  assign axi_resp_o.r       = sel_amo ? amo_r_q : burst_r;
  assign axi_resp_o.r_valid = amo_valid_q | ~ar_empty;

endmodule

// File: source/mem_subsys_top.sv
`timescale 1ns/10ps
// ##############################
// Memory subsystem top
// ##############################

module mem_subsys_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_axi_pkg::core_req_t core_req_i,
  input  logic                   core_qvalid_i,
  output logic                   core_qready_o,
  output mem_axi_pkg::core_rsp_t core_rsp_o,
  output logic                   core_pvalid_o,
  input  logic                   core_pready_i
);

  import mem_axi_pkg::*;

  axi_req_t  axi_req;   // adapter towards memory
  axi_resp_t axi_resp;  // memory back to adapter

  axi_adapter i_axi_adapter (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .core_req_i    ( core_req_i    ),
    .core_qvalid_i ( core_qvalid_i ),
    .core_qready_o ( core_qready_o ),
    .core_rsp_o    ( core_rsp_o    ),
    .core_pvalid_o ( core_pvalid_o ),
    .core_pready_i ( core_pready_i ),
    .axi_req_o     ( axi_req       ),
    .axi_resp_i    ( axi_resp      )
  );

  axi_atomic_mem i_axi_atomic_mem (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .axi_req_i  ( axi_req  ),
    .axi_resp_o ( axi_resp )
  );

endmodule

// File: dv/tb_mem_subsys.sv
`timescale 1ns/10ps
// ##############################
// Memory subsystem testbench
// ##############################

`include "mem_axi_settings.svh"

module tb_mem_subsys;

  import mem_axi_pkg::*;

  localparam int unsigned WAIT_LIMIT = 2000;  // cycles that any single wait may take
  localparam int unsigned WORDS      = `MEM_AXI_MEM_WORDS;
  localparam int unsigned IDX_W      = $clog2(`MEM_AXI_MEM_WORDS);
  localparam int unsigned MAX_WORD   = (2 ** (`MEM_AXI_ADDR_WIDTH - 2)) - 1;

  typedef logic [`MEM_AXI_DATA_WIDTH-1:0] word_t;
  typedef logic [`MEM_AXI_ADDR_WIDTH-1:0] addr_t;

  logic      clk_i;
  logic      rst_n_i;
  core_req_t core_req_i;
  logic      core_qvalid_i;
  logic      core_qready_o;
  core_rsp_t core_rsp_o;
  logic      core_pvalid_o;
  logic      core_pready_i;

  word_t       ref_mem [WORDS];  // mirror of the DUT memory
  core_rsp_t   exp_q [$];        // responses in the order the core must see them
  int unsigned errors;
  int unsigned timeouts;
  int unsigned beats;
  bit          req_seen;
  bit          stall_en;
  bit          hold_prev;
  core_rsp_t   rsp_prev;

  mem_subsys_top dut0 (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .core_req_i    ( core_req_i    ),
    .core_qvalid_i ( core_qvalid_i ),
    .core_qready_o ( core_qready_o ),
    .core_rsp_o    ( core_rsp_o    ),
    .core_pvalid_o ( core_pvalid_o ),
    .core_pready_i ( core_pready_i )
  );

  always #50 clk_i = ~clk_i;

  // random back-pressure stalls roughly one cycle in four
  always @(posedge clk_i) begin
    #1;
    core_pready_i = stall_en ? ($urandom_range(3) != 0) : 1'b1;
  end

  // inputs only change just after the rising edge, so the falling edge sees settled values
  always @(negedge clk_i) begin
    core_rsp_t exp;
    if (rst_n_i) begin
      if (!req_seen) begin
        assert (!core_pvalid_o) else begin
          $display("a response was offered before any request had been sent");
          errors++;
        end
      end
      if (hold_prev) begin
        assert (core_pvalid_o) else begin
          $display("response valid dropped while the core was stalling it");
          errors++;
        end
        assert (core_rsp_o == rsp_prev) else begin
          $display("ERROR core_rsp_o: got 0x%h, held 0x%h", core_rsp_o, rsp_prev);
          errors++;
        end
      end
      if (core_pvalid_o && core_pready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("a response arrived with none outstanding");
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          beats++;
          assert (core_rsp_o.data == exp.data) else begin
            $display("ERROR core_rsp_o.data: got 0x%h, expected 0x%h", core_rsp_o.data,
                     exp.data);
            errors++;
          end
          assert (core_rsp_o.id == exp.id) else begin
            $display("ERROR core_rsp_o.id: got 0x%h, expected 0x%h", core_rsp_o.id, exp.id);
            errors++;
          end
          assert (core_rsp_o.error == exp.error) else begin
            $display("ERROR core_rsp_o.error: got 0x%h, expected 0x%h", core_rsp_o.error,
                     exp.error);
            errors++;
          end
          assert (core_rsp_o.last == exp.last) else begin
            $display("ERROR core_rsp_o.last: got 0x%h, expected 0x%h", core_rsp_o.last,
                     exp.last);
            errors++;
          end
        end
      end
      hold_prev = core_pvalid_o && !core_pready_i;
      rsp_prev  = core_rsp_o;
    end
  end

  function automatic word_t fill_word(input addr_t addr);
    return {addr ^ 16'hA5C3, ~addr};
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'($urandom_range(WORDS - 1) * 4);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t data,
                                        input logic [STRB_WIDTH-1:0] strb);
    word_t res;
    res = old;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // RISC-V semantics of the memory update where AND is a plain and
  function automatic word_t amo_result(input amo_op_t op, input word_t old, input word_t opd);
    case (op)
      AMO_SWAP: return opd;
      AMO_ADD:  return old + opd;
      AMO_AND:  return old & opd;
      AMO_OR:   return old | opd;
      AMO_XOR:  return old ^ opd;
      AMO_MAX:  return ($signed(old) > $signed(opd)) ? old : opd;
      AMO_MAXU: return (old > opd) ? old : opd;
      AMO_MIN:  return ($signed(old) < $signed(opd)) ? old : opd;
      AMO_MINU: return (old < opd) ? old : opd;
      default:  return old;
    endcase
  endfunction

  function automatic core_req_t build_req(input addr_t addr, input logic write,
                                          input amo_op_t op, input word_t data,
                                          input logic [STRB_WIDTH-1:0] strb,
                                          input logic [7:0] rlen);
    core_req_t req;
    req.addr  = addr;
    req.write = write;
    req.amo   = op;
    req.data  = data;
    req.strb  = strb;
    req.rlen  = rlen;
    req.id    = `MEM_AXI_ID_WIDTH'($urandom);
    return req;
  endfunction

  task automatic finish_run();
    $display("beats checked: %0d, errors: %0d, timeouts: %0d", beats, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // updates the memory mirror and queues the responses an accepted request will produce
  task automatic update_model(input core_req_t req);
    logic [31:0] word;
    logic [31:0] cur;
    core_rsp_t   exp;
    word = 32'(req.addr) >> 2;
    if (req.amo inside {AMO_NONE, AMO_LR, AMO_SC}) begin
      if (req.write) begin
        if (word < WORDS) begin
          ref_mem[word[IDX_W-1:0]] = merge_bytes(ref_mem[word[IDX_W-1:0]], req.data,
                                                 req.strb);
        end
      end else begin
        for (int k = 0; k <= int'(req.rlen); k++) begin
          cur       = word + 32'(k);
          exp.data  = (cur < WORDS) ? ref_mem[cur[IDX_W-1:0]] : '0;
          exp.id    = req.id;
          exp.error = (cur >= WORDS);
          exp.last  = (k == int'(req.rlen));
          exp_q.push_back(exp);
        end
      end
    end else begin
      exp.data  = (word < WORDS) ? ref_mem[word[IDX_W-1:0]] : '0;
      exp.id    = req.id;
      exp.error = (word >= WORDS);
      exp.last  = 1'b1;
      exp_q.push_back(exp);
      if (word < WORDS) begin
        ref_mem[word[IDX_W-1:0]] = amo_result(req.amo, ref_mem[word[IDX_W-1:0]], req.data);
      end
    end
  endtask

  // called just after a rising edge and returns just after the edge that took the request
  task automatic send_req(input core_req_t req);
    int unsigned waited;
    bit          taken;
    if (timeouts != 0) return;  // nothing more is sent once a wait has timed out
    waited        = 0;
    taken         = 1'b0;
    req_seen      = 1'b1;
    core_req_i    = req;
    core_qvalid_i = 1'b1;
    while (!taken && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      taken = core_qready_o;
      @(posedge clk_i);
      #1;
      waited++;
    end
    core_qvalid_i = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("the request to address 0x%h was never accepted", req.addr);
    end else begin
      update_model(req);
    end
  endtask

  task automatic wait_idle();
    int unsigned waited;
    if (timeouts != 0) return;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("%0d responses never arrived", exp_q.size());
    end
  endtask

  initial begin
    addr_t      addr;
    word_t      data;
    amo_op_t    op;
    logic [7:0] len;
    void'($urandom(95));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    core_req_i    = '0;
    core_qvalid_i = 1'b0;
    core_pready_i = 1'b1;
    errors        = 0;
    timeouts      = 0;
    beats         = 0;
    req_seen      = 1'b0;
    stall_en      = 1'b0;
    hold_prev     = 1'b0;
    rsp_prev      = '0;
    repeat (8) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    repeat (4) @(posedge clk_i);  // the checker watches pvalid stay low while the bus is idle
    #1;

    // known contents everywhere before anything is read back
    for (int w = 0; w < int'(WORDS); w++) begin
      addr = addr_t'(w * 4);
      send_req(build_req(addr, 1'b1, AMO_NONE, fill_word(addr), '1, 8'd0));
    end

    stall_en = 1'b1;
    repeat (20) begin
      addr = rand_addr();
      send_req(build_req(addr, 1'b1, AMO_NONE, $urandom, STRB_WIDTH'($urandom), 8'd0));
      send_req(build_req(addr, 1'b0, AMO_NONE, '0, '0, 8'd0));
      wait_idle();
    end

    repeat (12) begin
      len  = 8'($urandom_range(7));
      addr = addr_t'($urandom_range(WORDS - 9) * 4);
      send_req(build_req(addr, 1'b0, AMO_NONE, '0, '0, len));
      wait_idle();
    end

    // every AMO code is run several times and read back after each
    for (int i = 0; i < 66; i++) begin
      op   = amo_op_t'(4'(i % 11 + 1));
      addr = rand_addr();
      data = $urandom;
      if (op == AMO_LR) send_req(build_req(addr, 1'b0, op, '0, '0, 8'd0));
      else if (op == AMO_SC) send_req(build_req(addr, 1'b1, op, data, '1, 8'd0));
      else send_req(build_req(addr, 1'b0, op, data, '1, 8'd0));
      wait_idle();
      send_req(build_req(addr, 1'b0, AMO_NONE, '0, '0, 8'd0));
      wait_idle();
    end

    repeat (6) begin
      addr = addr_t'($urandom_range(MAX_WORD, WORDS) * 4);
      send_req(build_req(addr, 1'b1, AMO_NONE, $urandom, '1, 8'd0));
      send_req(build_req(addr, 1'b0, AMO_NONE, '0, '0, 8'd0));
      wait_idle();
      send_req(build_req(addr, 1'b0, AMO_SWAP, $urandom, '1, 8'd0));
      wait_idle();
      // the word the address would alias to must be untouched
      send_req(build_req(addr & addr_t'(WORDS * 4 - 1), 1'b0, AMO_NONE, '0, '0, 8'd0));
      wait_idle();
    end
    send_req(build_req(addr_t'((WORDS - 2) * 4), 1'b0, AMO_NONE, '0, '0, 8'd3));
    wait_idle();

    // back to back reads so that the AR queue fills under stalls
    repeat (30) begin
      len  = 8'($urandom_range(3));
      addr = addr_t'($urandom_range(WORDS - 4) * 4);
      send_req(build_req(addr, 1'b0, AMO_NONE, '0, '0, len));
    end
    wait_idle();

    finish_run();
  end

endmodule

// File: src.f
+incdir+source
source/mem_axi_pkg.sv
source/stream_fifo.sv
source/axi_adapter.sv
source/axi_atomic_mem.sv
source/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f src.f -o sim_tb \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
